//--- Makefile
TOP := video_unit_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f filelist.f --Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q "test failed" sim.log; then echo "simulation reported a failure"; exit 1; fi
	@grep -q "test passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- filelist.f
hw/video_pkg.sv
hw/pxl_rate_gen.sv
hw/video_regs.sv
hw/crt_timing.sv
hw/line_buffer.sv
hw/pixel_fetch.sv
hw/video_unit.sv
testbench/video_unit_checker.sv
testbench/video_unit_tb.sv

//--- hw/crt_timing.sv
`timescale 1ns/1ps

module crt_timing (
   input  logic                 pxl_clk,
   input  logic                 rst,
   input  logic                 pxl_ce,
   input  logic                 enable,
   input  video_pkg::crt_cfg_t  crt_cfg,
   input  video_pkg::fb_cfg_t   fb_cfg,
   output video_pkg::line_pos_t line_pos,
   output logic                 hsync_s2,
   output logic                 vsync_s2
);

   video_pkg::crt_count_t h_cnt;
   video_pkg::crt_count_t v_cnt;
   logic                  h_in_sync;
   logic                  v_in_sync;
   video_pkg::line_pos_t  pos_nxt;

   // Stage 1, counters parked at 0 while the display is off
   always_ff @(posedge pxl_clk or posedge rst) begin
      if (rst) begin
         h_cnt <= '0;
         v_cnt <= '0;
      end else if (!enable) begin
         h_cnt <= '0;
         v_cnt <= '0;
      end else if (pxl_ce) begin
         if (h_cnt == crt_cfg.h_total - 16'd1) begin
            h_cnt <= '0;
            if (v_cnt == crt_cfg.v_total - 16'd1)
               v_cnt <= '0;
            else
               v_cnt <= v_cnt + 16'd1;
         end else begin
            h_cnt <= h_cnt + 16'd1;
         end
      end
   end

   assign h_in_sync = (h_cnt >= crt_cfg.h_srt_sync) && (h_cnt < crt_cfg.h_end_sync);
   assign v_in_sync = (v_cnt >= crt_cfg.v_srt_sync) && (v_cnt < crt_cfg.v_end_sync);

   always_comb begin
      pos_nxt.in_fb_rows  = v_cnt < video_pkg::crt_count_t'(fb_cfg.fb_height);
      pos_nxt.fb_active   = pos_nxt.in_fb_rows &&
                            (h_cnt < video_pkg::crt_count_t'(fb_cfg.fb_width));
      pos_nxt.line_start  = pos_nxt.in_fb_rows && (h_cnt == '0);
      pos_nxt.line_odd    = v_cnt[0];
      pos_nxt.disp_active = (h_cnt < crt_cfg.h_end_disp) && (v_cnt < crt_cfg.v_end_disp);
   end

   // Stage 2, syncs driven to the inactive level outside the pulse
   always_ff @(posedge pxl_clk or posedge rst) begin
      if (rst) begin
         line_pos <= '0;
         hsync_s2 <= 1'b0;
         vsync_s2 <= 1'b0;
      end else if (!enable) begin
         line_pos <= '0;
         hsync_s2 <= 1'b0;
         vsync_s2 <= 1'b0;
      end else if (pxl_ce) begin
         line_pos <= pos_nxt;
         hsync_s2 <= h_in_sync ? !crt_cfg.hsync_pol : crt_cfg.hsync_pol;
         vsync_s2 <= v_in_sync ? !crt_cfg.vsync_pol : crt_cfg.vsync_pol;
      end
   end

endmodule

//--- hw/line_buffer.sv
`timescale 1ns/1ps

module line_buffer (
   input  logic                pxl_clk,
   input  video_pkg::lb_be_t   lb_we,
   input  video_pkg::lb_addr_t lb_addr,
   input  video_pkg::lb_word_t lb_wrdata,
   input  logic                rd_en,
   input  video_pkg::lb_addr_t rd_addr,
   output video_pkg::lb_word_t rd_data
);

   // Lower half holds even lines, upper half odd lines
   video_pkg::lb_word_t mem [video_pkg::LB_WORDS];

   initial begin
      foreach (mem[i])
         mem[i] = '0;
   end

   always_ff @(posedge pxl_clk) begin
      for (int i = 0; i < $bits(video_pkg::lb_be_t); i++) begin
         if (lb_we[i])
            mem[lb_addr][i*8 +: 8] <= lb_wrdata[i*8 +: 8];
      end
   end

   // Registered read for the scan-out side
   always_ff @(posedge pxl_clk) begin
      if (rd_en)
         rd_data <= mem[rd_addr];
   end

endmodule

//--- hw/pixel_fetch.sv
`timescale 1ns/1ps

module pixel_fetch (
   input  logic                 pxl_clk,
   input  logic                 rst,
   input  logic                 pxl_ce,
   input  logic                 enable,
   input  video_pkg::fb_cfg_t   fb_cfg,
   input  video_pkg::line_pos_t line_pos,
   input  logic                 hsync_s2,
   input  logic                 vsync_s2,
   output logic                 rd_en,
   output video_pkg::lb_addr_t  rd_addr,
   input  video_pkg::lb_word_t  rd_data,
   output logic [7:0]           red,
   output logic [7:0]           green,
   output logic [7:0]           blue,
   output logic                 hsync,
   output logic                 vsync
);

   video_pkg::lb_addr_t addr_q;
   video_pkg::lb_addr_t cur_addr;
   logic [5:0]          off_q;
   logic [5:0]          cur_off;
   logic [5:0]          off_s3;
   logic [6:0]          step;
   logic [6:0]          next_off;
   logic                fb_s3;
   logic                disp_s3;
   video_pkg::lb_word_t slice_src;
   video_pkg::rgb_t     pxl_color;
   video_pkg::rgb_t     disp_color;

   function automatic video_pkg::rgb_t unpack16(input logic [15:0] c);
      return {c[15:11], c[15:13], c[10:5], c[10:9], c[4:0], c[4:2]};
   endfunction

   function automatic video_pkg::rgb_t unpack8(input logic [7:0] c);
      return {{2{c[7:5]}}, c[7:6], {2{c[4:2]}}, c[4:3], {4{c[1:0]}}};
   endfunction

   always_comb begin
      case (fb_cfg.depth)
         video_pkg::DEPTH_32: step = 7'd32;
         video_pkg::DEPTH_16: step = 7'd16;
         video_pkg::DEPTH_8:  step = 7'd8;
         default:             step = 7'd4;
      endcase
   end

   // A new framebuffer line restarts at the base of its half
   assign cur_addr = line_pos.line_start ? {line_pos.line_odd, 8'd0} : addr_q;
   assign cur_off  = line_pos.line_start ? 6'd0 : off_q;
   // Carry out means the last slice of this word
   assign next_off = {1'b0, cur_off} + step;

   assign rd_en   = pxl_ce && line_pos.fb_active;
   assign rd_addr = cur_addr;

   always_ff @(posedge pxl_clk or posedge rst) begin
      if (rst) begin
         addr_q <= '0;
         off_q  <= '0;
      end else if (pxl_ce && line_pos.in_fb_rows) begin
         if (next_off[6]) begin
            addr_q <= cur_addr + 9'd1;
            off_q  <= 6'd0;
         end else begin
            addr_q <= cur_addr;
            off_q  <= next_off[5:0];
         end
      end
   end

   // Stage 3, keeps syncs aligned with the RAM read
   always_ff @(posedge pxl_clk or posedge rst) begin
      if (rst) begin
         hsync   <= 1'b0;
         vsync   <= 1'b0;
         fb_s3   <= 1'b0;
         disp_s3 <= 1'b0;
      end else if (!enable) begin
         hsync   <= 1'b0;
         vsync   <= 1'b0;
         fb_s3   <= 1'b0;
         disp_s3 <= 1'b0;
      end else if (pxl_ce) begin
         hsync   <= hsync_s2;
         vsync   <= vsync_s2;
         fb_s3   <= line_pos.fb_active;
         disp_s3 <= line_pos.disp_active;
      end
   end

   always_ff @(posedge pxl_clk) begin
      if (pxl_ce)
         off_s3 <= cur_off;
   end

   assign slice_src = rd_data >> off_s3;

   always_comb begin
      case (fb_cfg.depth)
         video_pkg::DEPTH_32: pxl_color = slice_src[23:0];
         video_pkg::DEPTH_16: pxl_color = unpack16(slice_src[15:0]);
         video_pkg::DEPTH_8:  pxl_color = unpack8(slice_src[7:0]);
         default:             pxl_color = {6{slice_src[3:0]}};
      endcase
   end

   // Background inside the display window but outside the framebuffer
   assign disp_color = (enable && disp_s3) ? (fb_s3 ? pxl_color : fb_cfg.bg_color) : '0;

   assign red   = disp_color[23:16];
   assign green = disp_color[15:8];
   assign blue  = disp_color[7:0];

endmodule

//--- hw/pxl_rate_gen.sv
`timescale 1ns/1ps

module pxl_rate_gen (
   input  logic                 pxl_clk,
   input  logic                 rst,
   input  video_pkg::pxl_freq_t pxl_freq,
   output logic                 pxl_ce
);

   // Phase stays below the modulus
   logic [7:0] acc;
   // One bit wider so the sum cannot overflow
   logic [8:0] sum;
   logic [8:0] sum_wrapped;

   assign sum         = {1'b0, acc} + {1'b0, pxl_freq};
   assign sum_wrapped = sum - video_pkg::PXL_RATE_FULL;

   always_ff @(posedge pxl_clk or posedge rst) begin
      if (rst) begin
         acc    <= 8'd0;
         pxl_ce <= 1'b1;
      end else if (sum >= video_pkg::PXL_RATE_FULL) begin
         acc    <= sum_wrapped[7:0];
         pxl_ce <= 1'b1;
      end else begin
         acc    <= sum[7:0];
         pxl_ce <= 1'b0;
      end
   end

endmodule

//--- hw/video_pkg.sv
package video_pkg;

   // Widths that carry a meaning
   typedef logic [4:0]  reg_addr_t;
   typedef logic [31:0] reg_data_t;
   typedef logic [15:0] crt_count_t;
   typedef logic [11:0] fb_dim_t;
   typedef logic [23:0] rgb_t;
   typedef logic [8:0]  lb_addr_t;
   typedef logic [63:0] lb_word_t;
   typedef logic [7:0]  lb_be_t;
   typedef logic [7:0]  pxl_freq_t;

   typedef enum logic [1:0] {
      DEPTH_32 = 2'd0,
      DEPTH_16 = 2'd1,
      DEPTH_8  = 2'd2,
      DEPTH_4  = 2'd3
   } color_depth_t;

   // Register map, one word per register
   localparam reg_addr_t REG_DEPTH      = 5'd2;
   localparam reg_addr_t REG_ENABLE     = 5'd3;
   localparam reg_addr_t REG_POLARITY   = 5'd4;
   localparam reg_addr_t REG_PXLFREQ    = 5'd5;
   localparam reg_addr_t REG_FB_WIDTH   = 5'd6;
   localparam reg_addr_t REG_FB_HEIGHT  = 5'd7;
   localparam reg_addr_t REG_BG_COLOR   = 5'd9;
   localparam reg_addr_t REG_H_TOTAL    = 5'd16;
   localparam reg_addr_t REG_H_END_DISP = 5'd17;
   localparam reg_addr_t REG_H_SRT_SYNC = 5'd18;
   localparam reg_addr_t REG_H_END_SYNC = 5'd19;
   localparam reg_addr_t REG_V_TOTAL    = 5'd20;
   localparam reg_addr_t REG_V_END_DISP = 5'd21;
   localparam reg_addr_t REG_V_SRT_SYNC = 5'd22;
   localparam reg_addr_t REG_V_END_SYNC = 5'd23;

   // Clock-enable modulus, pixel rate is pxl_freq/125 per clock
   localparam logic [8:0] PXL_RATE_FULL = 9'd125;

   localparam int LB_WORDS = 512;

   typedef struct packed {
      crt_count_t h_total;
      crt_count_t h_end_disp;
      crt_count_t h_srt_sync;
      crt_count_t h_end_sync;
      crt_count_t v_total;
      crt_count_t v_end_disp;
      crt_count_t v_srt_sync;
      crt_count_t v_end_sync;
      logic       hsync_pol;
      logic       vsync_pol;
   } crt_cfg_t;

   typedef struct packed {
      color_depth_t depth;
      fb_dim_t      fb_width;
      fb_dim_t      fb_height;
      rgb_t         bg_color;
   } fb_cfg_t;

   typedef struct packed {
      logic line_start;
      logic line_odd;
      logic in_fb_rows;
      logic fb_active;
      logic disp_active;
   } line_pos_t;

   // Reset set is standard 640x480 with negative syncs
   localparam pxl_freq_t PXLFREQ_RST = 8'd25;
   localparam logic      ENABLE_RST  = 1'b0;

   localparam crt_cfg_t CRT_CFG_RST = '{
      h_total:    16'd800,
      h_end_disp: 16'd640,
      h_srt_sync: 16'd656,
      h_end_sync: 16'd752,
      v_total:    16'd525,
      v_end_disp: 16'd480,
      v_srt_sync: 16'd490,
      v_end_sync: 16'd492,
      hsync_pol:  1'b1,
      vsync_pol:  1'b1
   };

   localparam fb_cfg_t FB_CFG_RST = '{
      depth:     DEPTH_32,
      fb_width:  12'd640,
      fb_height: 12'd480,
      bg_color:  24'hFFFFFF
   };

endpackage

//--- hw/video_regs.sv
`timescale 1ns/1ps

module video_regs (
   input  logic                 pxl_clk,
   input  logic                 rst,
   input  logic                 reg_en,
   input  logic                 reg_we,
   input  video_pkg::reg_addr_t reg_addr,
   input  video_pkg::reg_data_t reg_wrdata,
   output video_pkg::reg_data_t reg_rddata,
   output video_pkg::crt_cfg_t  crt_cfg,
   output video_pkg::fb_cfg_t   fb_cfg,
   output logic                 enable,
   output video_pkg::pxl_freq_t pxl_freq
);

   logic wr_ok;

   // Only enable and background colour may change during scan-out
   assign wr_ok = reg_en && reg_we &&
                  (!enable ||
                   reg_addr == video_pkg::REG_ENABLE ||
                   reg_addr == video_pkg::REG_BG_COLOR);

   always_ff @(posedge pxl_clk or posedge rst) begin
      if (rst) begin
         crt_cfg  <= video_pkg::CRT_CFG_RST;
         fb_cfg   <= video_pkg::FB_CFG_RST;
         enable   <= video_pkg::ENABLE_RST;
         pxl_freq <= video_pkg::PXLFREQ_RST;
      end else if (wr_ok) begin
         case (reg_addr)
            video_pkg::REG_DEPTH:
               fb_cfg.depth <= video_pkg::color_depth_t'(reg_wrdata[1:0]);
            video_pkg::REG_ENABLE:     enable            <= reg_wrdata[0];
            video_pkg::REG_POLARITY: begin
               crt_cfg.vsync_pol <= reg_wrdata[1];
               crt_cfg.hsync_pol <= reg_wrdata[0];
            end
            video_pkg::REG_PXLFREQ:    pxl_freq          <= reg_wrdata[7:0];
            video_pkg::REG_FB_WIDTH:   fb_cfg.fb_width   <= reg_wrdata[11:0];
            video_pkg::REG_FB_HEIGHT:  fb_cfg.fb_height  <= reg_wrdata[11:0];
            video_pkg::REG_BG_COLOR:   fb_cfg.bg_color   <= reg_wrdata[23:0];
            video_pkg::REG_H_TOTAL:    crt_cfg.h_total    <= reg_wrdata[15:0];
            video_pkg::REG_H_END_DISP: crt_cfg.h_end_disp <= reg_wrdata[15:0];
            video_pkg::REG_H_SRT_SYNC: crt_cfg.h_srt_sync <= reg_wrdata[15:0];
            video_pkg::REG_H_END_SYNC: crt_cfg.h_end_sync <= reg_wrdata[15:0];
            video_pkg::REG_V_TOTAL:    crt_cfg.v_total    <= reg_wrdata[15:0];
            video_pkg::REG_V_END_DISP: crt_cfg.v_end_disp <= reg_wrdata[15:0];
            video_pkg::REG_V_SRT_SYNC: crt_cfg.v_srt_sync <= reg_wrdata[15:0];
            video_pkg::REG_V_END_SYNC: crt_cfg.v_end_sync <= reg_wrdata[15:0];
            default: ;
         endcase
      end
   end

   // Read data is valid one cycle after the request
   always_ff @(posedge pxl_clk) begin
      if (reg_en) begin
         case (reg_addr)
            video_pkg::REG_DEPTH:      reg_rddata <= {30'd0, fb_cfg.depth};
            video_pkg::REG_ENABLE:     reg_rddata <= {31'd0, enable};
            video_pkg::REG_POLARITY:
               reg_rddata <= {30'd0, crt_cfg.vsync_pol, crt_cfg.hsync_pol};
            video_pkg::REG_PXLFREQ:    reg_rddata <= {24'd0, pxl_freq};
            video_pkg::REG_FB_WIDTH:   reg_rddata <= {20'd0, fb_cfg.fb_width};
            video_pkg::REG_FB_HEIGHT:  reg_rddata <= {20'd0, fb_cfg.fb_height};
            video_pkg::REG_BG_COLOR:   reg_rddata <= {8'd0, fb_cfg.bg_color};
            video_pkg::REG_H_TOTAL:    reg_rddata <= {16'd0, crt_cfg.h_total};
            video_pkg::REG_H_END_DISP: reg_rddata <= {16'd0, crt_cfg.h_end_disp};
            video_pkg::REG_H_SRT_SYNC: reg_rddata <= {16'd0, crt_cfg.h_srt_sync};
            video_pkg::REG_H_END_SYNC: reg_rddata <= {16'd0, crt_cfg.h_end_sync};
            video_pkg::REG_V_TOTAL:    reg_rddata <= {16'd0, crt_cfg.v_total};
            video_pkg::REG_V_END_DISP: reg_rddata <= {16'd0, crt_cfg.v_end_disp};
            video_pkg::REG_V_SRT_SYNC: reg_rddata <= {16'd0, crt_cfg.v_srt_sync};
            video_pkg::REG_V_END_SYNC: reg_rddata <= {16'd0, crt_cfg.v_end_sync};
            default:                   reg_rddata <= '0;
         endcase
      end
   end

endmodule

//--- hw/video_unit.sv
`timescale 1ns/1ps

module video_unit (
   input  logic                 pxl_clk,
   input  logic                 rst,
   input  logic                 reg_en,
   input  logic                 reg_we,
   input  video_pkg::reg_addr_t reg_addr,
   input  video_pkg::reg_data_t reg_wrdata,
   output video_pkg::reg_data_t reg_rddata,
   input  video_pkg::lb_be_t    lb_we,
   input  video_pkg::lb_addr_t  lb_addr,
   input  video_pkg::lb_word_t  lb_wrdata,
   output logic [7:0]           red,
   output logic [7:0]           green,
   output logic [7:0]           blue,
   output logic                 hsync,
   output logic                 vsync
);

   video_pkg::crt_cfg_t  crt_cfg;
   video_pkg::fb_cfg_t   fb_cfg;
   logic                 enable;
   video_pkg::pxl_freq_t pxl_freq;
   logic                 pxl_ce;
   video_pkg::line_pos_t line_pos;
   logic                 hsync_s2;
   logic                 vsync_s2;
   logic                 rd_en;
   video_pkg::lb_addr_t  rd_addr;
   video_pkg::lb_word_t  rd_data;

   video_regs u_regs (
      .pxl_clk    (pxl_clk),
      .rst        (rst),
      .reg_en     (reg_en),
      .reg_we     (reg_we),
      .reg_addr   (reg_addr),
      .reg_wrdata (reg_wrdata),
      .reg_rddata (reg_rddata),
      .crt_cfg    (crt_cfg),
      .fb_cfg     (fb_cfg),
      .enable     (enable),
      .pxl_freq   (pxl_freq)
   );

   pxl_rate_gen u_rate (
      .pxl_clk  (pxl_clk),
      .rst      (rst),
      .pxl_freq (pxl_freq),
      .pxl_ce   (pxl_ce)
   );

   crt_timing u_timing (
      .pxl_clk  (pxl_clk),
      .rst      (rst),
      .pxl_ce   (pxl_ce),
      .enable   (enable),
      .crt_cfg  (crt_cfg),
      .fb_cfg   (fb_cfg),
      .line_pos (line_pos),
      .hsync_s2 (hsync_s2),
      .vsync_s2 (vsync_s2)
   );

   line_buffer u_lbuf (
      .pxl_clk   (pxl_clk),
      .lb_we     (lb_we),
      .lb_addr   (lb_addr),
      .lb_wrdata (lb_wrdata),
      .rd_en     (rd_en),
      .rd_addr   (rd_addr),
      .rd_data   (rd_data)
   );

   pixel_fetch u_fetch (
      .pxl_clk  (pxl_clk),
      .rst      (rst),
      .pxl_ce   (pxl_ce),
      .enable   (enable),
      .fb_cfg   (fb_cfg),
      .line_pos (line_pos),
      .hsync_s2 (hsync_s2),
      .vsync_s2 (vsync_s2),
      .rd_en    (rd_en),
      .rd_addr  (rd_addr),
      .rd_data  (rd_data),
      .red      (red),
      .green    (green),
      .blue     (blue),
      .hsync    (hsync),
      .vsync    (vsync)
   );

endmodule

//--- testbench/video_stimulus.txt
# W/R: addr data (hex)   L: byte_en addr word (hex)   P: h v rgb (dec dec hex)
# F: hsync width and period in clocks (dec)
R 10 320
R 14 20D
R 05 19
R 04 3
R 09 FFFFFF
R 02 0
R 03 0
R 01 0
R 1F 0
W 05 7D
W 04 0
W 10 14
W 11 0C
W 12 0E
W 13 11
W 14 0C
W 15 08
W 16 09
W 17 0A
W 06 8
W 07 6
W 02 2
L FF 000 0123456789ABCDEF
L FF 001 F80007E0001FFFFF
L FF 100 FEDCBA9876543210
L 0F 101 FFFFFFFF00002222
L F0 101 00001111FFFFFFFF
W 03 1
W 10 40
R 10 14
W 09 123456
R 09 123456
F 3 20
P 0 0 FF6DFF
P 2 2 B649FF
P 1 1 2492AA
P 7 3 FFFFAA
W 03 0
W 05 19
W 03 1
F 15 100
W 03 0
W 05 7D
W 02 1
W 03 1
P 0 0 CEBE7B
P 5 2 0000FF
P 6 4 00FF00
P 7 0 FF0000
P 1 3 73CBA5
P 4 1 214510
P 6 3 10208C
P 9 1 123456
P 3 7 123456
P 13 2 000000
P 2 9 000000
W 03 0
W 02 3
W 03 1
P 0 2 FFFFFF
P 3 0 CCCCCC
P 7 4 888888
P 6 1 666666
P 2 3 222222
P 10 5 123456
P 15 1 000000

//--- testbench/video_unit_checker.sv
`timescale 1ns/1ps

module video_unit_checker (
   input logic       pxl_clk,
   input logic       rst,
   input logic       enable,
   input logic [7:0] red,
   input logic [7:0] green,
   input logic [7:0] blue,
   input logic       hsync,
   input logic       vsync
);

   // Display off gives a black screen at once and quiet syncs one cycle later
   black_while_disabled: assert property (
      @(posedge pxl_clk) disable iff (rst)
      !enable |-> (red == 8'd0 && green == 8'd0 && blue == 8'd0 &&
                   ($past(enable) || (!hsync && !vsync))))
      else $error("outputs not quiet while the display is disabled");

   // Syncs come out of reset inactive
   syncs_low_after_reset: assert property (
      @(posedge pxl_clk) rst |=> (!hsync && !vsync))
      else $error("hsync or vsync active one cycle after reset");

endmodule

bind video_unit video_unit_checker u_checker (
   .pxl_clk (pxl_clk),
   .rst     (rst),
   .enable  (enable),
   .red     (red),
   .green   (green),
   .blue    (blue),
   .hsync   (hsync),
   .vsync   (vsync)
);

//--- testbench/video_unit_tb.sv
`timescale 1ns/1ps

module video_unit_tb;

   localparam int  TIMEOUT_CYCLES = 2000;
   localparam time DRIVE_DLY      = 5ns;

   logic                 pxl_clk;
   logic                 rst;
   logic                 reg_en;
   logic                 reg_we;
   video_pkg::reg_addr_t reg_addr;
   video_pkg::reg_data_t reg_wrdata;
   video_pkg::reg_data_t reg_rddata;
   video_pkg::lb_be_t    lb_we;
   video_pkg::lb_addr_t  lb_addr;
   video_pkg::lb_word_t  lb_wrdata;
   logic [7:0]           red;
   logic [7:0]           green;
   logic [7:0]           blue;
   logic                 hsync;
   logic                 vsync;

   // Register contents as the bus master expects them
   video_pkg::reg_data_t shadow [32];
   int                   passes;
   int                   fails;

   video_unit UUT (
      .pxl_clk    (pxl_clk),
      .rst        (rst),
      .reg_en     (reg_en),
      .reg_we     (reg_we),
      .reg_addr   (reg_addr),
      .reg_wrdata (reg_wrdata),
      .reg_rddata (reg_rddata),
      .lb_we      (lb_we),
      .lb_addr    (lb_addr),
      .lb_wrdata  (lb_wrdata),
      .red        (red),
      .green      (green),
      .blue       (blue),
      .hsync      (hsync),
      .vsync      (vsync)
   );

   initial begin
      pxl_clk = 1'b0;
      forever #50 pxl_clk = ~pxl_clk;
   end

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      assert (exp === act)
         else $display("[FAIL] %s expected %h actual %h", name, exp, act);
      if (exp === act) begin
         passes++;
         $display("[PASS] %s", name);
      end else begin
         fails++;
      end
   endtask

   task automatic reg_write(input video_pkg::reg_addr_t a, input video_pkg::reg_data_t d);
      @(posedge pxl_clk);
      #(DRIVE_DLY);
      reg_en     = 1'b1;
      reg_we     = 1'b1;
      reg_addr   = a;
      reg_wrdata = d;
      @(posedge pxl_clk);
      #(DRIVE_DLY);
      reg_en = 1'b0;
      reg_we = 1'b0;
      // Only enable and background colour are writable during scan-out
      if (!shadow[video_pkg::REG_ENABLE][0] || a == video_pkg::REG_ENABLE ||
          a == video_pkg::REG_BG_COLOR)
         shadow[a] = d;
   endtask

   task automatic reg_read(input video_pkg::reg_addr_t a, input video_pkg::reg_data_t exp);
      @(posedge pxl_clk);
      #(DRIVE_DLY);
      reg_en   = 1'b1;
      reg_we   = 1'b0;
      reg_addr = a;
      @(posedge pxl_clk);
      #(DRIVE_DLY);
      reg_en = 1'b0;
      check_value($sformatf("read reg %02h", a), exp, reg_rddata);
   endtask

   task automatic lb_write(input video_pkg::lb_be_t be, input video_pkg::lb_addr_t a,
                           input video_pkg::lb_word_t d);
      @(posedge pxl_clk);
      #(DRIVE_DLY);
      lb_we     = be;
      lb_addr   = a;
      lb_wrdata = d;
      @(posedge pxl_clk);
      #(DRIVE_DLY);
      lb_we = '0;
   endtask

   // Returns at the first sample where the chosen sync turns active
   task automatic wait_rise(input bit use_vsync, output bit ok);
      logic prev;
      logic cur;
      ok = 1'b0;
      @(negedge pxl_clk);
      prev = use_vsync ? vsync : hsync;
      for (int i = 0; i < TIMEOUT_CYCLES; i++) begin
         @(negedge pxl_clk);
         cur = use_vsync ? vsync : hsync;
         if (!prev && cur) begin
            ok = 1'b1;
            break;
         end
         prev = cur;
      end
      if (!ok) begin
         $display("timeout while waiting for %s to become active",
                  use_vsync ? "vsync" : "hsync");
         fails++;
      end
   endtask

   task automatic pixel_check(input int h, input int v, input logic [23:0] exp);
      int ht;
      int vt;
      int n;
      bit ok;
      ht = int'(shadow[video_pkg::REG_H_TOTAL]);
      vt = int'(shadow[video_pkg::REG_V_TOTAL]);
      // Reference point is the sample at (h_srt_sync, v_srt_sync)
      wait_rise(1'b1, ok);
      if (ok)
         wait_rise(1'b0, ok);
      if (!ok)
         return;
      n = ((v + vt - int'(shadow[video_pkg::REG_V_SRT_SYNC])) % vt) * ht +
          h - int'(shadow[video_pkg::REG_H_SRT_SYNC]);
      if (n < 0)
         n += ht * vt;
      repeat (n) @(negedge pxl_clk);
      check_value($sformatf("pixel (%0d,%0d)", h, v), {8'd0, exp}, {8'd0, red, green, blue});
   endtask

   task automatic sync_timing_check(input int exp_width, input int exp_period);
      int width;
      int period;
      bit high;
      bit ok;
      bit done;
      wait_rise(1'b0, ok);
      if (!ok)
         return;
      width  = 1;
      period = 1;
      high   = 1'b1;
      done   = 1'b0;
      for (int i = 0; i < TIMEOUT_CYCLES; i++) begin
         @(negedge pxl_clk);
         if (high) begin
            if (hsync)
               width++;
            else
               high = 1'b0;
         end else if (hsync) begin
            done = 1'b1;
            break;
         end
         period++;
      end
      if (!done) begin
         $display("timeout while measuring the hsync period");
         fails++;
         return;
      end
      check_value("hsync width", exp_width, width);
      check_value("hsync period", exp_period, period);
   endtask

   // Turn the display off while a pixel is lit and expect quiet outputs in two cycles
   task automatic mute_check();
      bit lit;
      lit = 1'b0;
      for (int i = 0; i < TIMEOUT_CYCLES; i++) begin
         @(negedge pxl_clk);
         if ({red, green, blue} != 24'd0) begin
            lit = 1'b1;
            break;
         end
      end
      if (!lit) begin
         $display("timeout while waiting for a lit pixel before the disable");
         fails++;
         return;
      end
      reg_write(video_pkg::REG_ENABLE, 32'd0);
      for (int i = 0; i < 2; i++) begin
         @(negedge pxl_clk);
         if (!hsync && !vsync && {red, green, blue} == 24'd0)
            break;
      end
      check_value("mute on disable", 32'd0, {6'd0, hsync, vsync, red, green, blue});
   endtask

   task automatic run_stimulus();
      int                fd;
      int                n;
      int                h;
      int                v;
      logic [7:0]        op;
      logic [63:0]       f1;
      logic [63:0]       f2;
      logic [63:0]       f3;
      logic [8*160-1:0]  line;
      fd = $fopen("testbench/video_stimulus.txt", "r");
      if (fd == 0) begin
         $display("cannot open testbench/video_stimulus.txt");
         fails++;
         return;
      end
      while (!$feof(fd)) begin
         n = $fscanf(fd, " %c", op);
         if (n != 1)
            break;
         case (op)
            "#": n = $fgets(line, fd);
            "W": begin
               n = $fscanf(fd, "%h %h", f1, f2);
               reg_write(f1[4:0], f2[31:0]);
            end
            "R": begin
               n = $fscanf(fd, "%h %h", f1, f2);
               reg_read(f1[4:0], f2[31:0]);
            end
            "L": begin
               n = $fscanf(fd, "%h %h %h", f1, f2, f3);
               lb_write(f1[7:0], f2[8:0], f3);
            end
            "P": begin
               n = $fscanf(fd, "%d %d %h", h, v, f1);
               pixel_check(h, v, f1[23:0]);
            end
            "F": begin
               n = $fscanf(fd, "%d %d", h, v);
               sync_timing_check(h, v);
            end
            default: begin
               $display("unknown opcode %c in the stimulus file", op);
               fails++;
               n = $fgets(line, fd);
            end
         endcase
      end
      $fclose(fd);
   endtask

   initial begin
      rst        = 1'b1;
      reg_en     = 1'b0;
      reg_we     = 1'b0;
      reg_addr   = '0;
      reg_wrdata = '0;
      lb_we      = '0;
      lb_addr    = '0;
      lb_wrdata  = '0;
      passes     = 0;
      fails      = 0;
      foreach (shadow[i])
         shadow[i] = '0;
      repeat (5) @(posedge pxl_clk);
      #(DRIVE_DLY);
      rst = 1'b0;
      run_stimulus();
      mute_check();
      $display("tests: %0d passed, %0d failed", passes, fails);
      if (fails == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule
